// ==== isa_pkg.sv ====
package isa_pkg;

   typedef logic [3:0] opcode_t;

   // Opcode values in the top nibble of the instruction word
   localparam opcode_t OPC_ADD = 4'h0;
   localparam opcode_t OPC_SUB = 4'h1;
   localparam opcode_t OPC_AND = 4'h2;
   localparam opcode_t OPC_NOR = 4'h3;
   localparam opcode_t OPC_SLL = 4'h4;
   localparam opcode_t OPC_SRL = 4'h5;
   localparam opcode_t OPC_SRA = 4'h6;
   localparam opcode_t OPC_LLB = 4'hA;
   localparam opcode_t OPC_LHB = 4'hB;

   // Field positions
   localparam int OPC_HI   = 15;
   localparam int OPC_LO   = 12;
   localparam int RD_HI    = 11;
   localparam int RD_LO    = 8;
   localparam int RS_HI    = 7;
   localparam int RS_LO    = 4;
   localparam int RT_HI    = 3;
   localparam int RT_LO    = 0;
   localparam int SHAMT_HI = 3;   // Shifts only
   localparam int SHAMT_LO = 0;
   localparam int IMM_HI   = 7;   // Byte loads only
   localparam int IMM_LO   = 0;

endpackage

// ==== dp_pkg.sv ====
package dp_pkg;

   localparam int WORD_W     = 16;
   localparam int REG_ADDR_W = 4;
   localparam int NUM_REGS   = 1 << REG_ADDR_W;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // ALU operations with OP_NONE for idle and undefined opcodes
   typedef enum logic [3:0] {
      OP_NONE,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_NOR,
      OP_SLL,
      OP_SRL,
      OP_SRA,
      OP_LLB,
      OP_LHB
   } alu_op_t;

   typedef struct packed {
      logic z;
      logic v;
      logic n;
   } flags_t;

endpackage

// ==== dp_if.sv ====
`timescale 1ns/1ps

// Decoder outputs to register file and ALU
interface decode_bus;
   import dp_pkg::*;

   alu_op_t   op;
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   reg_addr_t rd_addr;
   logic      re0;
   logic      re1;
   logic [7:0] imm8;
   logic [3:0] shamt;
   logic      we;

   modport dec (output op, rs_addr, rt_addr, rd_addr, re0, re1, imm8, shamt, we);
   modport rf  (input rs_addr, rt_addr, rd_addr, re0, re1, we);
   modport alu (input op, imm8, shamt);

endinterface

// ALU result and raw flags
interface alu_bus;
   import dp_pkg::*;

   word_t   result;
   flags_t  flags;
   alu_op_t op;

   modport src (output result, flags, op);
   modport rf  (input result);
   modport flg (input flags, op);

endinterface

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
   parameter bit zero_r0 = 1'b0
) (
   input  logic              clk,
   input  logic              rst,
   decode_bus.rf             dec,
   alu_bus.rf                res,
   output dp_pkg::word_t     rd0,
   output dp_pkg::word_t     rd1,
   input  dp_pkg::reg_addr_t dbg_addr,
   output dp_pkg::word_t     dbg_data
);
   import dp_pkg::*;

   word_t               regs [NUM_REGS];
   word_t               view [NUM_REGS];
   logic [NUM_REGS-1:0] wr_sel;

   // One-hot write strobes
   always_comb begin
      wr_sel = '0;
      if (dec.we) begin
         wr_sel[dec.rd_addr] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_REGS; i++) begin
         if (rst) begin
            regs[i] <= '0;
         end else if (wr_sel[i]) begin
            regs[i] <= res.result;
         end
      end
   end

   // Read view with r0 hard-wired when requested
   always_comb begin
      view = regs;
      if (zero_r0) begin
         view[0] = '0;
      end
   end

   assign rd0      = dec.re0 ? view[dec.rs_addr] : '0;
   assign rd1      = dec.re1 ? view[dec.rt_addr] : '0;
   assign dbg_data = view[dbg_addr];   // Always enabled

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
   input  dp_pkg::word_t instr,
   input  logic          instr_valid,
   decode_bus.dec        dec
);
   import isa_pkg::*;
   import dp_pkg::*;

   opcode_t   opc;
   reg_addr_t rd;

   assign opc = instr[OPC_HI:OPC_LO];
   assign rd  = instr[RD_HI:RD_LO];

   always_comb begin
      dec.op      = OP_NONE;
      dec.re0     = 1'b0;
      dec.re1     = 1'b0;
      dec.rd_addr = rd;
      dec.rs_addr = instr[RS_HI:RS_LO];
      dec.rt_addr = instr[RT_HI:RT_LO];
      dec.imm8    = instr[IMM_HI:IMM_LO];
      dec.shamt   = instr[SHAMT_HI:SHAMT_LO];

      if (instr_valid) begin
         case (opc)
            OPC_ADD: dec.op = OP_ADD;
            OPC_SUB: dec.op = OP_SUB;
            OPC_AND: dec.op = OP_AND;
            OPC_NOR: dec.op = OP_NOR;
            OPC_SLL: dec.op = OP_SLL;
            OPC_SRL: dec.op = OP_SRL;
            OPC_SRA: dec.op = OP_SRA;
            OPC_LLB: dec.op = OP_LLB;
            OPC_LHB: dec.op = OP_LHB;
            default: dec.op = OP_NONE;   // No-op
         endcase
      end

      case (dec.op)
         OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
            dec.re0 = 1'b1;
            dec.re1 = 1'b1;
         end
         OP_SLL, OP_SRL, OP_SRA: dec.re0 = 1'b1;
         OP_LLB, OP_LHB: begin
            // Other byte of rd comes back on port 0
            dec.rs_addr = rd;
            dec.re0     = 1'b1;
         end
         default: ;
      endcase

      dec.we = (dec.op != OP_NONE);
   end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
   decode_bus.alu        dec,
   input  dp_pkg::word_t a,
   input  dp_pkg::word_t b,
   alu_bus.src           res
);
   import dp_pkg::*;

   localparam int    MSB     = WORD_W - 1;
   localparam word_t SAT_MAX = {1'b0, {MSB{1'b1}}};
   localparam word_t SAT_MIN = {1'b1, {MSB{1'b0}}};

   word_t sum;
   word_t diff;
   word_t sat_val;
   logic  ovf_add;
   logic  ovf_sub;
   word_t result;
   logic  ovf;

   assign sum  = a + b;
   assign diff = a - b;

   // Signed overflow
   assign ovf_add = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
   assign ovf_sub = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

   // Clamp toward the sign of a
   assign sat_val = a[MSB] ? SAT_MIN : SAT_MAX;

   always_comb begin
      result = '0;
      ovf    = 1'b0;
      case (dec.op)
         OP_ADD: begin
            ovf    = ovf_add;
            result = ovf_add ? sat_val : sum;
         end
         OP_SUB: begin
            ovf    = ovf_sub;
            result = ovf_sub ? sat_val : diff;
         end
         OP_AND: result = a & b;
         OP_NOR: result = ~(a | b);
         OP_SLL: result = a << dec.shamt;
         OP_SRL: result = a >> dec.shamt;
         OP_SRA: result = word_t'($signed(a) >>> dec.shamt);
         OP_LLB: result = {a[MSB:8], dec.imm8};   // Keep high byte
         OP_LHB: result = {dec.imm8, a[7:0]};     // Keep low byte
         default: result = '0;
      endcase
   end

   assign res.result  = result;
   assign res.flags.z = (result == '0);
   assign res.flags.v = ovf;
   assign res.flags.n = result[MSB];
   assign res.op      = dec.op;

endmodule

// ==== flag_reg.sv ====
`timescale 1ns/1ps

module flag_reg (
   input  logic           clk,
   input  logic           rst,
   alu_bus.flg            res,
   output dp_pkg::flags_t flags
);
   import dp_pkg::*;

   always_ff @(posedge clk) begin
      if (rst) begin
         flags <= '0;
      end else begin
         case (res.op)
            OP_ADD, OP_SUB: flags <= res.flags;                     // All three
            OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA: flags.z <= res.flags.z;
            default: flags <= flags;   // Byte loads and idle hold
         endcase
      end
   end

endmodule

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
   parameter bit zero_r0 = 1'b0
) (
   input  logic              clk,
   input  logic              rst,
   input  dp_pkg::word_t     instr,
   input  logic              instr_valid,
   input  dp_pkg::reg_addr_t dbg_addr,
   output dp_pkg::word_t     dbg_data,
   output logic              flags_z,
   output logic              flags_v,
   output logic              flags_n
);
   import dp_pkg::*;

   word_t  rd0;
   word_t  rd1;
   flags_t flags;

   decode_bus decode_bus_i ();
   alu_bus    alu_bus_i ();

   inst_decode inst_decode_i (
      .instr       (instr),
      .instr_valid (instr_valid),
      .dec         (decode_bus_i.dec)
   );

   reg_file #(
      .zero_r0 (zero_r0)
   ) reg_file_i (
      .clk      (clk),
      .rst      (rst),
      .dec      (decode_bus_i.rf),
      .res      (alu_bus_i.rf),
      .rd0      (rd0),
      .rd1      (rd1),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

   alu alu_i (
      .dec (decode_bus_i.alu),
      .a   (rd0),
      .b   (rd1),
      .res (alu_bus_i.src)
   );

   flag_reg flag_reg_i (
      .clk   (clk),
      .rst   (rst),
      .res   (alu_bus_i.flg),
      .flags (flags)
   );

   assign flags_z = flags.z;
   assign flags_v = flags.v;
   assign flags_n = flags.n;

endmodule

// ==== tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;

   localparam int CLK_PERIOD      = 4;
   localparam int NUM_TESTS       = 40;
   localparam int COLS            = 4;   // Words per line in the data file
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 5 + 50;

   logic        clk;
   logic        rst;
   logic [15:0] instr;
   logic        instr_valid;
   logic [3:0]  dbg_addr;
   logic [15:0] dbg_data;
   logic        flags_z;
   logic        flags_v;
   logic        flags_n;

   logic [15:0] vec [COLS*NUM_TESTS];
   logic [31:0] lfsr_state;
   int          test_errs;
   int          total_errs;
   int          failed_tests;

   exec_core exec_core_i (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .instr_valid (instr_valid),
      .dbg_addr    (dbg_addr),
      .dbg_data    (dbg_data),
      .flags_z     (flags_z),
      .flags_v     (flags_v),
      .flags_n     (flags_n)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // Galois form with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[14:0], lfsr_state[0]};
      end
   endtask

   // Z, V, N packed as bits 2, 1, 0
   function automatic logic [15:0] cur_flags();
      return {13'd0, flags_z, flags_v, flags_n};
   endfunction

   task automatic check_word(
      input string       name,
      input logic [15:0] exp,
      input logic [15:0] act
   );
      assert (act === exp) else begin
         $display("Mismatch %s expected %h actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic report_test(input string label);
      if (test_errs == 0) begin
         $display("test %s: ok", label);
      end else begin
         $display("test %s: %0d errors", label, test_errs);
         failed_tests++;
      end
      total_errs += test_errs;
   endtask

   // Sweep the debug port over all registers
   task automatic check_reset();
      for (int a = 0; a < 16; a++) begin
         @(posedge clk);
         dbg_addr <= a[3:0];
         #1;
         check_word($sformatf("dbg_data r%0d", a), 16'h0000, dbg_data);
      end
      check_word("flags", 16'h0000, cur_flags());
   endtask

   task automatic run_test(input int t);
      logic [15:0] w;
      logic [3:0]  addr;
      logic [15:0] exp_val;
      logic [15:0] exp_flags;
      logic [15:0] gap;
      logic [15:0] noise;

      w         = vec[COLS*t];
      addr      = vec[COLS*t+1][3:0];
      exp_val   = vec[COLS*t+2];
      exp_flags = vec[COLS*t+3];
      test_errs = 0;

      @(posedge clk);
      instr       <= w;
      instr_valid <= 1'b1;
      @(posedge clk);   // Write edge
      instr_valid <= 1'b0;
      dbg_addr    <= addr;
      #1;
      check_word("dbg_data", exp_val, dbg_data);
      check_word("flags", exp_flags, cur_flags());

      // Idle cycles with junk on instr
      draw_bits(2, gap);
      repeat (gap) begin
         @(posedge clk);
         draw_bits(16, noise);
         instr <= noise;
      end
      if (gap != 16'd0) begin
         #1;
         check_word("dbg_data after idle", exp_val, dbg_data);
         check_word("flags after idle", exp_flags, cur_flags());
      end

      report_test($sformatf("%0d instr %h r%0d", t, w, addr));
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      instr        = '0;
      instr_valid  = 1'b0;
      dbg_addr     = '0;
      lfsr_state   = 32'h74cc;
      test_errs    = 0;
      total_errs   = 0;
      failed_tests = 0;
      $readmemh("exec_input.txt", vec);

      repeat (3) @(posedge clk);
      rst <= 1'b0;

      check_reset();
      report_test("reset");

      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end

      $display("%0d tests run, %0d failed, %0d errors",
               NUM_TESTS + 1, failed_tests, total_errs);
      if (total_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== exec_input.txt ====
// Columns: instruction word, debug register address, expected register value,
// expected flags as one digit with Z in bit 2, V in bit 1, N in bit 0
// Byte loads build words, flags stay clear
A134 1 0034 0
B112 1 1234 0
A2FF 2 00FF 0
B27F 2 7FFF 0
A300 3 0000 0
B380 3 8000 0
A401 4 0001 0
// Add and subtract, saturation on overflow
0512 5 7FFF 2
0614 6 1235 0
1734 7 8000 3
1811 8 0000 4
1941 9 EDCD 1
0A39 A 8000 3
// Logic ops touch only Z
2B12 B 1234 3
2C13 C 0000 7
3D12 D 8000 3
0E44 E 0002 0
1F41 F EDCD 1
// Shifts
4E14 E 2340 1
5D93 D 1DB9 1
6C94 C FEDC 1
4B31 B 0000 5
6A7F A FFFF 1
5A7F A 0001 1
// Undefined opcodes
7512 5 7FFF 1
F1FF 1 1234 1
C100 1 1234 1
// rd also a source
0111 1 2468 0
1141 1 DB99 1
4111 1 B732 1
A1AB 1 B7AB 1
B1CD 1 CDAB 1
// Byte loads keep V even on a zero result
0552 5 7FFF 2
A500 5 7F00 2
B500 5 0000 2
3655 6 FFFF 2
2766 7 FFFF 2
1866 8 0000 4
0936 9 8000 3
8000 0 0000 3

// ==== vlog.f ====
isa_pkg.sv
dp_pkg.sv
dp_if.sv
reg_file.sv
inst_decode.sv
alu.sv
flag_reg.sv
exec_core.sv
tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run from the project root
verilator --binary --timing --assert --top-module tb_exec_core -f vlog.f -o sim_exec_core \
   && ./obj_dir/sim_exec_core | tee sim.log \
   && grep -qx "TESTS PASSED" sim.log \
   || exit 1
